/* Makefile */
# Verilator build and run for the cache hierarchy testbench
# override any variable on the command line, e.g. make sim LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_cache_hierarchy
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Regression passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail, not the simulator exit code
sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
source/cache_pkg.sv
source/l1_cache.sv
source/memory_arbiter.sv
source/cache_hierarchy.sv
testbench/cache_hierarchy_asserts.sv
testbench/tb_cache_hierarchy.sv

/* source/cache_hierarchy.sv */
// split l1 caches sharing one memory bus, flush and clear go to both caches and each reports its own done
`timescale 1ns/100ps
`default_nettype none

module cache_hierarchy #(
  parameter int CACHE_WORDS = cache_pkg::DEF_CACHE_WORDS,
  parameter int BLOCK_WORDS = cache_pkg::DEF_BLOCK_WORDS,
  parameter logic [cache_pkg::ADDR_W-1:0] NONCACHE_START = cache_pkg::DEF_NONCACHE_START
) (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst_n,
  input  wire logic                         i_flush,
  input  wire logic                         i_clear,
  output logic                              o_iflush_done,
  output logic                              o_dflush_done,
  output logic                              o_iclear_done,
  output logic                              o_dclear_done,
  // instruction fetch port
  input  wire logic                         i_icpu_ren,
  input  wire logic                         i_icpu_wen,
  input  wire logic [cache_pkg::ADDR_W-1:0] i_icpu_addr,
  input  wire logic [cache_pkg::WORD_W-1:0] i_icpu_wdata,
  input  wire logic [cache_pkg::BE_W-1:0]   i_icpu_byte_en,
  output logic      [cache_pkg::WORD_W-1:0] o_icpu_rdata,
  output logic                              o_icpu_busy,
  // load/store port
  input  wire logic                         i_dcpu_ren,
  input  wire logic                         i_dcpu_wen,
  input  wire logic [cache_pkg::ADDR_W-1:0] i_dcpu_addr,
  input  wire logic [cache_pkg::WORD_W-1:0] i_dcpu_wdata,
  input  wire logic [cache_pkg::BE_W-1:0]   i_dcpu_byte_en,
  output logic      [cache_pkg::WORD_W-1:0] o_dcpu_rdata,
  output logic                              o_dcpu_busy,
  // shared memory bus
  output logic                              o_mem_ren,
  output logic                              o_mem_wen,
  output logic      [cache_pkg::ADDR_W-1:0] o_mem_addr,
  output logic      [cache_pkg::WORD_W-1:0] o_mem_wdata,
  output logic      [cache_pkg::BE_W-1:0]   o_mem_byte_en,
  input  wire logic [cache_pkg::WORD_W-1:0] i_mem_rdata,
  input  wire logic                         i_mem_busy
);
  import cache_pkg::*;

  // icache to arbiter
  logic              ic_ren;
  logic              ic_wen;
  logic [ADDR_W-1:0] ic_addr;
  logic [WORD_W-1:0] ic_wdata;
  logic [BE_W-1:0]   ic_byte_en;
  logic [WORD_W-1:0] ic_rdata;
  logic              ic_busy;
  // dcache to arbiter
  logic              dc_ren;
  logic              dc_wen;
  logic [ADDR_W-1:0] dc_addr;
  logic [WORD_W-1:0] dc_wdata;
  logic [BE_W-1:0]   dc_byte_en;
  logic [WORD_W-1:0] dc_rdata;
  logic              dc_busy;

  l1_cache #(
    .CACHE_WORDS(CACHE_WORDS), .BLOCK_WORDS(BLOCK_WORDS), .NONCACHE_START(NONCACHE_START)
  ) u_icache (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(i_flush), .i_clear(i_clear),
    .o_flush_done(o_iflush_done), .o_clear_done(o_iclear_done),
    .i_proc_ren(i_icpu_ren), .i_proc_wen(i_icpu_wen), .i_proc_addr(i_icpu_addr),
    .i_proc_wdata(i_icpu_wdata), .i_proc_byte_en(i_icpu_byte_en),
    .o_proc_rdata(o_icpu_rdata), .o_proc_busy(o_icpu_busy),
    .o_mem_ren(ic_ren), .o_mem_wen(ic_wen), .o_mem_addr(ic_addr), .o_mem_wdata(ic_wdata),
    .o_mem_byte_en(ic_byte_en), .i_mem_rdata(ic_rdata), .i_mem_busy(ic_busy)
  );

  l1_cache #(
    .CACHE_WORDS(CACHE_WORDS), .BLOCK_WORDS(BLOCK_WORDS), .NONCACHE_START(NONCACHE_START)
  ) u_dcache (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_flush(i_flush), .i_clear(i_clear),
    .o_flush_done(o_dflush_done), .o_clear_done(o_dclear_done),
    .i_proc_ren(i_dcpu_ren), .i_proc_wen(i_dcpu_wen), .i_proc_addr(i_dcpu_addr),
    .i_proc_wdata(i_dcpu_wdata), .i_proc_byte_en(i_dcpu_byte_en),
    .o_proc_rdata(o_dcpu_rdata), .o_proc_busy(o_dcpu_busy),
    .o_mem_ren(dc_ren), .o_mem_wen(dc_wen), .o_mem_addr(dc_addr), .o_mem_wdata(dc_wdata),
    .o_mem_byte_en(dc_byte_en), .i_mem_rdata(dc_rdata), .i_mem_busy(dc_busy)
  );

  memory_arbiter u_arb (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_icache_ren(ic_ren), .i_icache_wen(ic_wen), .i_icache_addr(ic_addr),
    .i_icache_wdata(ic_wdata), .i_icache_byte_en(ic_byte_en),
    .o_icache_rdata(ic_rdata), .o_icache_busy(ic_busy),
    .i_dcache_ren(dc_ren), .i_dcache_wen(dc_wen), .i_dcache_addr(dc_addr),
    .i_dcache_wdata(dc_wdata), .i_dcache_byte_en(dc_byte_en),
    .o_dcache_rdata(dc_rdata), .o_dcache_busy(dc_busy),
    .o_mem_ren(o_mem_ren), .o_mem_wen(o_mem_wen), .o_mem_addr(o_mem_addr),
    .o_mem_wdata(o_mem_wdata), .o_mem_byte_en(o_mem_byte_en),
    .i_mem_rdata(i_mem_rdata), .i_mem_busy(i_mem_busy)
  );

endmodule

`default_nettype wire

/* source/cache_pkg.sv */
// bus widths and default cache geometry for both caches, buses carry whole words at byte addresses
`default_nettype none

package cache_pkg;

  // generic bus widths
  localparam int WORD_W = 32;  // data word
  localparam int ADDR_W = 32;  // byte address
  localparam int BE_W   = WORD_W / 8;  // one enable per byte lane

  // default geometry, overridden per instance from the top level
  localparam int DEF_CACHE_WORDS = 64;  // capacity in words
  localparam int DEF_BLOCK_WORDS = 2;  // words per line

  // everything from here up goes straight to memory
  // this is the mmio window
  localparam logic [ADDR_W-1:0] DEF_NONCACHE_START = 32'hF000_0000;

endpackage

`default_nettype wire

/* source/l1_cache.sv */
// direct-mapped write-back cache for power-of-two CACHE_WORDS of at least two lines and BLOCK_WORDS of 1, 2 or 4, flush and clear start on a rising edge
`timescale 1ns/100ps
`default_nettype none

module l1_cache #(
  parameter int CACHE_WORDS = cache_pkg::DEF_CACHE_WORDS,
  parameter int BLOCK_WORDS = cache_pkg::DEF_BLOCK_WORDS,
  parameter logic [cache_pkg::ADDR_W-1:0] NONCACHE_START = cache_pkg::DEF_NONCACHE_START
) (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst_n,
  input  wire logic                         i_flush,  // write back then invalidate
  input  wire logic                         i_clear,  // invalidate only
  output logic                              o_flush_done,
  output logic                              o_clear_done,
  // processor side
  input  wire logic                         i_proc_ren,
  input  wire logic                         i_proc_wen,
  input  wire logic [cache_pkg::ADDR_W-1:0] i_proc_addr,
  input  wire logic [cache_pkg::WORD_W-1:0] i_proc_wdata,
  input  wire logic [cache_pkg::BE_W-1:0]   i_proc_byte_en,
  output logic      [cache_pkg::WORD_W-1:0] o_proc_rdata,
  output logic                              o_proc_busy,
  // memory side
  output logic                              o_mem_ren,
  output logic                              o_mem_wen,
  output logic      [cache_pkg::ADDR_W-1:0] o_mem_addr,
  output logic      [cache_pkg::WORD_W-1:0] o_mem_wdata,
  output logic      [cache_pkg::BE_W-1:0]   o_mem_byte_en,
  input  wire logic [cache_pkg::WORD_W-1:0] i_mem_rdata,
  input  wire logic                         i_mem_busy
);
  import cache_pkg::*;

  // address split, low to high: byte, word offset, index, tag
  localparam int N_LINES   = CACHE_WORDS / BLOCK_WORDS;
  localparam int IDX_W     = $clog2(N_LINES);
  localparam int BYTE_BITS = $clog2(BE_W);
  localparam int OFF_BITS  = $clog2(BLOCK_WORDS);  // zero for one-word lines
  localparam int WOFF_W    = (OFF_BITS > 0) ? OFF_BITS : 1;
  localparam int IDX_LSB   = BYTE_BITS + OFF_BITS;
  localparam int TAG_LSB   = IDX_LSB + IDX_W;
  localparam int TAG_W     = ADDR_W - TAG_LSB;

  // controller states
  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_LOOKUP   = 3'd1;
  localparam logic [2:0] S_WB       = 3'd2;  // victim writeback
  localparam logic [2:0] S_FILL     = 3'd3;
  localparam logic [2:0] S_BYPASS   = 3'd4;  // mmio transfer
  localparam logic [2:0] S_BYP_DONE = 3'd5;
  localparam logic [2:0] S_FLUSH    = 3'd6;
  localparam logic [2:0] S_CLEAR    = 3'd7;

  // storage
  logic [WORD_W-1:0] data_mem [N_LINES][BLOCK_WORDS];
  logic [TAG_W-1:0]  tag_mem  [N_LINES];
  logic [N_LINES-1:0] valid;
  logic [N_LINES-1:0] dirty;

  logic [2:0]        state;
  logic [WOFF_W-1:0] word_cnt;  // word within the line being moved
  logic [WOFF_W-1:0] word_nxt;
  logic [IDX_W-1:0]  line_cnt;  // flush/clear walk pointer
  logic [WORD_W-1:0] byp_rdata;  // mmio read data, held one cycle
  logic              flush_q;
  logic              clear_q;
  logic              flush_pend;  // edge seen, waiting for idle
  logic              clear_pend;

  // request decode
  logic              proc_req;
  logic              noncache;
  logic [TAG_W-1:0]  req_tag;
  logic [IDX_W-1:0]  req_idx;
  logic [WOFF_W-1:0] req_off;
  logic              hit;

  logic              word_last;
  logic              line_last;
  logic [IDX_W-1:0]  wb_idx;  // line being written back
  logic              flush_wb;  // flush walk sits on a dirty line
  logic              line_step;  // flush/clear done with current line

  // rebuild a word address from its fields
  function automatic logic [ADDR_W-1:0] line_addr(input logic [TAG_W-1:0]  tag,
                                                   input logic [IDX_W-1:0]  idx,
                                                   input logic [WOFF_W-1:0] off);
    line_addr = (ADDR_W'(tag) << TAG_LSB) | (ADDR_W'(idx) << IDX_LSB) |
                (ADDR_W'(off) << BYTE_BITS);
  endfunction

  assign proc_req = i_proc_ren | i_proc_wen;
  assign noncache = (i_proc_addr >= NONCACHE_START);
  assign req_tag  = i_proc_addr[TAG_LSB +: TAG_W];
  assign req_idx  = i_proc_addr[IDX_LSB +: IDX_W];
  assign req_off  = (OFF_BITS > 0) ? i_proc_addr[BYTE_BITS +: WOFF_W] : '0;
  assign hit      = valid[req_idx] && (tag_mem[req_idx] == req_tag);

  assign word_last = (word_cnt == WOFF_W'(BLOCK_WORDS - 1));
  assign word_nxt  = word_last ? '0 : word_cnt + 1'b1;
  assign line_last = (line_cnt == IDX_W'(N_LINES - 1));
  assign wb_idx    = (state == S_FLUSH) ? line_cnt : req_idx;
  assign flush_wb  = (state == S_FLUSH) && valid[line_cnt] && dirty[line_cnt];
  assign line_step = ((state == S_FLUSH) || (state == S_CLEAR)) &&
                     (!flush_wb || (!i_mem_busy && word_last));

  // cpu side, hit answers straight from the array
  assign o_proc_rdata = (state == S_BYP_DONE) ? byp_rdata : data_mem[req_idx][req_off];
  assign o_proc_busy  = !((state == S_LOOKUP && proc_req && hit) ||
                          (state == S_BYP_DONE && proc_req));

  // controller
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= S_IDLE;
      word_cnt     <= '0;
      line_cnt     <= '0;
      valid        <= '0;
      dirty        <= '0;
      flush_q      <= 1'b0;
      clear_q      <= 1'b0;
      flush_pend   <= 1'b0;
      clear_pend   <= 1'b0;
      o_flush_done <= 1'b0;
      o_clear_done <= 1'b0;
    end else begin
      flush_q      <= i_flush;
      clear_q      <= i_clear;
      o_flush_done <= 1'b0;  // done is a single pulse
      o_clear_done <= 1'b0;
      if (i_flush && !flush_q) flush_pend <= 1'b1;
      if (i_clear && !clear_q) clear_pend <= 1'b1;
      case (state)
        S_IDLE: begin
          word_cnt <= '0;
          line_cnt <= '0;
          if (flush_pend) begin  // maintenance beats cpu traffic
            flush_pend <= 1'b0;
            state      <= S_FLUSH;
          end else if (clear_pend) begin
            clear_pend <= 1'b0;
            state      <= S_CLEAR;
          end else if (proc_req) begin
            state <= noncache ? S_BYPASS : S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (!proc_req) begin
            state <= S_IDLE;
          end else if (hit) begin
            state <= S_IDLE;
            if (i_proc_wen) dirty[req_idx] <= 1'b1;
          end else if (valid[req_idx] && dirty[req_idx]) begin
            state <= S_WB;  // evict first
          end else begin
            state <= S_FILL;
          end
        end
        S_WB: begin
          if (!i_mem_busy) begin
            word_cnt <= word_nxt;
            if (word_last) state <= S_FILL;
          end
        end
        S_FILL: begin
          if (!i_mem_busy) begin
            word_cnt <= word_nxt;
            if (word_last) begin
              valid[req_idx] <= 1'b1;
              dirty[req_idx] <= 1'b0;
              state          <= S_LOOKUP;  // replay as a hit
            end
          end
        end
        S_BYPASS: begin
          if (!i_mem_busy) state <= S_BYP_DONE;
        end
        S_BYP_DONE: state <= S_IDLE;
        S_FLUSH, S_CLEAR: begin
          if (flush_wb && !i_mem_busy) word_cnt <= word_nxt;
          if (line_step) begin
            valid[line_cnt] <= 1'b0;
            dirty[line_cnt] <= 1'b0;
            line_cnt        <= line_cnt + 1'b1;
            if (line_last) begin
              state        <= S_IDLE;
              o_flush_done <= (state == S_FLUSH);
              o_clear_done <= (state == S_CLEAR);
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // arrays and mmio capture
  always_ff @(posedge i_clk) begin
    if (state == S_FILL && !i_mem_busy) begin
      data_mem[req_idx][word_cnt] <= i_mem_rdata;
      if (word_last) tag_mem[req_idx] <= req_tag;
    end
    if (state == S_LOOKUP && proc_req && hit && i_proc_wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (i_proc_byte_en[b]) begin  // merge enabled lanes only
          data_mem[req_idx][req_off][8*b +: 8] <= i_proc_wdata[8*b +: 8];
        end
      end
    end
    if (state == S_BYPASS && !i_mem_busy) byp_rdata <= i_mem_rdata;
  end

  // memory side request, held steady by the stalled controller
  always_comb begin
    o_mem_ren     = 1'b0;
    o_mem_wen     = (state == S_WB) || flush_wb;
    o_mem_addr    = line_addr(tag_mem[wb_idx], wb_idx, word_cnt);
    o_mem_wdata   = data_mem[wb_idx][word_cnt];
    o_mem_byte_en = '1;  // line traffic moves whole words
    case (state)
      S_FILL: begin
        o_mem_ren  = 1'b1;
        o_mem_addr = line_addr(req_tag, req_idx, word_cnt);
      end
      S_BYPASS: begin
        o_mem_ren     = i_proc_ren;
        o_mem_wen     = i_proc_wen;
        o_mem_addr    = i_proc_addr;
        o_mem_wdata   = i_proc_wdata;
        o_mem_byte_en = i_proc_byte_en;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* source/memory_arbiter.sv */
// fixed priority two-to-one bus arbiter with zero added latency, a side that never drops its request holds the bus
`timescale 1ns/100ps
`default_nettype none

module memory_arbiter (
  input  wire logic                         i_clk,
  input  wire logic                         i_rst_n,
  // instruction cache side
  input  wire logic                         i_icache_ren,
  input  wire logic                         i_icache_wen,
  input  wire logic [cache_pkg::ADDR_W-1:0] i_icache_addr,
  input  wire logic [cache_pkg::WORD_W-1:0] i_icache_wdata,
  input  wire logic [cache_pkg::BE_W-1:0]   i_icache_byte_en,
  output logic      [cache_pkg::WORD_W-1:0] o_icache_rdata,
  output logic                              o_icache_busy,
  // data cache side, wins ties
  input  wire logic                         i_dcache_ren,
  input  wire logic                         i_dcache_wen,
  input  wire logic [cache_pkg::ADDR_W-1:0] i_dcache_addr,
  input  wire logic [cache_pkg::WORD_W-1:0] i_dcache_wdata,
  input  wire logic [cache_pkg::BE_W-1:0]   i_dcache_byte_en,
  output logic      [cache_pkg::WORD_W-1:0] o_dcache_rdata,
  output logic                              o_dcache_busy,
  // memory side
  output logic                              o_mem_ren,
  output logic                              o_mem_wen,
  output logic      [cache_pkg::ADDR_W-1:0] o_mem_addr,
  output logic      [cache_pkg::WORD_W-1:0] o_mem_wdata,
  output logic      [cache_pkg::BE_W-1:0]   o_mem_byte_en,
  input  wire logic [cache_pkg::WORD_W-1:0] i_mem_rdata,
  input  wire logic                         i_mem_busy
);

  localparam logic [1:0] OWN_NONE = 2'd0;
  localparam logic [1:0] OWN_I    = 2'd1;
  localparam logic [1:0] OWN_D    = 2'd2;

  logic [1:0] owner;  // locked side while memory stalls
  logic [1:0] grant;  // side driving the bus this cycle
  logic       ireq;
  logic       dreq;
  logic       gnt_i;
  logic       gnt_d;
  logic       gnt_req;  // granted side is asking

  assign ireq = i_icache_ren | i_icache_wen;
  assign dreq = i_dcache_ren | i_dcache_wen;

  // idle grant is combinational so no cycle is added
  always_comb begin
    grant = owner;
    if (owner == OWN_NONE) begin
      if (dreq) begin
        grant = OWN_D;
      end else if (ireq) begin
        grant = OWN_I;
      end
    end
  end

  assign gnt_i   = (grant == OWN_I);
  assign gnt_d   = (grant == OWN_D);
  assign gnt_req = (gnt_i & ireq) | (gnt_d & dreq);

  // lock while stalled, release on completion
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      owner <= OWN_NONE;
    end else begin
      owner <= (gnt_req && i_mem_busy) ? grant : OWN_NONE;
    end
  end

  // request mux
  always_comb begin
    o_mem_ren     = 1'b0;
    o_mem_wen     = 1'b0;
    o_mem_addr    = '0;
    o_mem_wdata   = '0;
    o_mem_byte_en = '0;
    if (gnt_d) begin
      o_mem_ren     = i_dcache_ren;
      o_mem_wen     = i_dcache_wen;
      o_mem_addr    = i_dcache_addr;
      o_mem_wdata   = i_dcache_wdata;
      o_mem_byte_en = i_dcache_byte_en;
    end else if (gnt_i) begin
      o_mem_ren     = i_icache_ren;
      o_mem_wen     = i_icache_wen;
      o_mem_addr    = i_icache_addr;
      o_mem_wdata   = i_icache_wdata;
      o_mem_byte_en = i_icache_byte_en;
    end
  end

  // response only reaches the granted side
  assign o_icache_busy  = !(gnt_i && ireq && !i_mem_busy);
  assign o_dcache_busy  = !(gnt_d && dreq && !i_mem_busy);
  assign o_icache_rdata = gnt_i ? i_mem_rdata : '0;
  assign o_dcache_rdata = gnt_d ? i_mem_rdata : '0;

endmodule

`default_nettype wire

/* testbench/cache_hierarchy_asserts.sv */
// bus protocol checks on the hierarchy ports that stay quiet while reset is low
`timescale 1ns/100ps
`default_nettype none

module cache_hierarchy_asserts (
  input wire logic                         i_clk,
  input wire logic                         i_rst_n,
  input wire logic                         o_mem_ren,
  input wire logic                         o_mem_wen,
  input wire logic [cache_pkg::ADDR_W-1:0] o_mem_addr,
  input wire logic [cache_pkg::WORD_W-1:0] o_mem_wdata,
  input wire logic [cache_pkg::BE_W-1:0]   o_mem_byte_en,
  input wire logic                         i_mem_busy,
  input wire logic                         i_icpu_ren,
  input wire logic                         i_icpu_wen,
  input wire logic                         o_icpu_busy,
  input wire logic                         i_dcpu_ren,
  input wire logic                         i_dcpu_wen,
  input wire logic                         o_dcpu_busy,
  input wire logic                         o_iflush_done,
  input wire logic                         o_dflush_done,
  input wire logic                         o_iclear_done,
  input wire logic                         o_dclear_done
);

  a_mem_rw_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_mem_ren && o_mem_wen)) else $error("mem ren and wen high together");

  // stalled request must not move
  a_mem_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ((o_mem_ren || o_mem_wen) && i_mem_busy) |=>
      ($stable(o_mem_ren) && $stable(o_mem_wen) && $stable(o_mem_addr) &&
       $stable(o_mem_wdata) && $stable(o_mem_byte_en)))
    else $error("mem request changed while busy");

  // busy never drops in the first cycle of a request
  a_icpu_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !o_icpu_busy |-> (i_icpu_ren || i_icpu_wen) && $past(i_icpu_ren || i_icpu_wen))
    else $error("icpu busy low without a held request");
  a_dcpu_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !o_dcpu_busy |-> (i_dcpu_ren || i_dcpu_wen) && $past(i_dcpu_ren || i_dcpu_wen))
    else $error("dcpu busy low without a held request");

  // done pulses are one cycle wide
  a_iflush_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_iflush_done |=> !o_iflush_done) else $error("iflush done longer than a cycle");
  a_dflush_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_dflush_done |=> !o_dflush_done) else $error("dflush done longer than a cycle");
  a_iclear_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_iclear_done |=> !o_iclear_done) else $error("iclear done longer than a cycle");
  a_dclear_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_dclear_done |=> !o_dclear_done) else $error("dclear done longer than a cycle");

endmodule

bind cache_hierarchy cache_hierarchy_asserts u_asserts (.*);

`default_nettype wire

/* testbench/tb_cache_hierarchy.sv */
// 1024-word random-latency memory model sees only address bits 11:2 so mmio aliases low words
`timescale 1ns/100ps
`default_nettype none

module tb_cache_hierarchy;
  import cache_pkg::*;

  localparam int CLK_NS        = 8;
  localparam int MEM_WORDS     = 1024;
  localparam int N_TESTS       = 6;
  localparam int N_LINES       = DEF_CACHE_WORDS / DEF_BLOCK_WORDS;
  localparam int XFER_CYCLES   = 5;  // four busy cycles then the completing one
  localparam int ACCESS_CYCLES = 2 * DEF_BLOCK_WORDS * XFER_CYCLES + 4;  // evict, fill, lookup
  localparam int FLUSH_CYCLES  = N_LINES * (DEF_BLOCK_WORDS * XFER_CYCLES + 1);
  localparam int WORST_CYCLES  = 8 * ACCESS_CYCLES + 2 * FLUSH_CYCLES;  // both caches walk
  localparam logic [ADDR_W-1:0] MMIO_BASE = DEF_NONCACHE_START;

  logic              clk;
  logic              rst_n;
  logic              flush;
  logic              clear;
  logic              iflush_done;
  logic              dflush_done;
  logic              iclear_done;
  logic              dclear_done;
  logic              icpu_ren;
  logic              icpu_wen;
  logic [ADDR_W-1:0] icpu_addr;
  logic [WORD_W-1:0] icpu_wdata;
  logic [BE_W-1:0]   icpu_be;
  logic [WORD_W-1:0] icpu_rdata;
  logic              icpu_busy;
  logic              dcpu_ren;
  logic              dcpu_wen;
  logic [ADDR_W-1:0] dcpu_addr;
  logic [WORD_W-1:0] dcpu_wdata;
  logic [BE_W-1:0]   dcpu_be;
  logic [WORD_W-1:0] dcpu_rdata;
  logic              dcpu_busy;
  logic              mem_ren;
  logic              mem_wen;
  logic [ADDR_W-1:0] mem_addr;
  logic [WORD_W-1:0] mem_wdata;
  logic [BE_W-1:0]   mem_be;
  logic [WORD_W-1:0] mem_rdata;
  logic              mem_busy;

  logic [WORD_W-1:0] mem [MEM_WORDS];  // model storage
  int seed = 32'h8f85_7dbd;
  int lat_left;  // -1 while no transfer is pending
  int rd_count;
  int wr_count;
  int errors;
  int checks;

  cache_hierarchy i_dut (
    .i_clk(clk), .i_rst_n(rst_n), .i_flush(flush), .i_clear(clear),
    .o_iflush_done(iflush_done), .o_dflush_done(dflush_done),
    .o_iclear_done(iclear_done), .o_dclear_done(dclear_done),
    .i_icpu_ren(icpu_ren), .i_icpu_wen(icpu_wen), .i_icpu_addr(icpu_addr),
    .i_icpu_wdata(icpu_wdata), .i_icpu_byte_en(icpu_be),
    .o_icpu_rdata(icpu_rdata), .o_icpu_busy(icpu_busy),
    .i_dcpu_ren(dcpu_ren), .i_dcpu_wen(dcpu_wen), .i_dcpu_addr(dcpu_addr),
    .i_dcpu_wdata(dcpu_wdata), .i_dcpu_byte_en(dcpu_be),
    .o_dcpu_rdata(dcpu_rdata), .o_dcpu_busy(dcpu_busy),
    .o_mem_ren(mem_ren), .o_mem_wen(mem_wen), .o_mem_addr(mem_addr),
    .o_mem_wdata(mem_wdata), .o_mem_byte_en(mem_be),
    .i_mem_rdata(mem_rdata), .i_mem_busy(mem_busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // byte-lane merge as the bus defines it
  function automatic logic [WORD_W-1:0] merge_bytes(input logic [WORD_W-1:0] old_w,
                                                    input logic [WORD_W-1:0] new_w,
                                                    input logic [BE_W-1:0] be);
    logic [WORD_W-1:0] res;
    res = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic int widx(input logic [ADDR_W-1:0] addr);
    return int'(addr[11:2]);  // word index into the model
  endfunction

  // memory model drops busy for one cycle after 0..3 extra wait cycles
  always @(posedge clk) begin
    int lat;
    if (!rst_n) begin
      mem_busy <= 1'b1;
      lat_left <= -1;
    end else if (mem_ren || mem_wen) begin
      if (!mem_busy) begin  // transfer completes at this edge
        if (mem_wen) begin
          mem[widx(mem_addr)] <= merge_bytes(mem[widx(mem_addr)], mem_wdata, mem_be);
          wr_count <= wr_count + 1;
        end else begin
          rd_count <= rd_count + 1;
        end
        mem_busy <= 1'b1;
        lat_left <= -1;
      end else begin
        lat = (lat_left < 0) ? int'($unsigned($random(seed)) % 4) : lat_left;
        if (lat == 0) begin
          mem_busy  <= 1'b0;
          mem_rdata <= mem[widx(mem_addr)];
        end
        lat_left <= lat - 1;
      end
    end
  end

  task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                            input logic [WORD_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("Fail t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // one cpu transfer with the request held until busy drops
  task automatic cpu_access(input bit dport, input bit write, input logic [ADDR_W-1:0] addr,
                            input logic [WORD_W-1:0] wdata, input logic [BE_W-1:0] be,
                            output logic [WORD_W-1:0] rdata);
    logic busy;
    @(posedge clk);
    if (dport) begin
      dcpu_ren   <= !write;
      dcpu_wen   <= write;
      dcpu_addr  <= addr;
      dcpu_wdata <= wdata;
      dcpu_be    <= be;
    end else begin
      icpu_ren   <= !write;
      icpu_wen   <= write;
      icpu_addr  <= addr;
      icpu_wdata <= wdata;
      icpu_be    <= be;
    end
    do begin
      @(posedge clk);
      busy = dport ? dcpu_busy : icpu_busy;  // pre-edge value
    end while (busy);
    rdata = dport ? dcpu_rdata : icpu_rdata;
    if (dport) begin
      dcpu_ren <= 1'b0;
      dcpu_wen <= 1'b0;
    end else begin
      icpu_ren <= 1'b0;
      icpu_wen <= 1'b0;
    end
    @(negedge clk);  // model writes settled
  endtask

  // pulses flush or clear for one cycle and waits for both caches to report
  task automatic maintain(input bit do_flush);
    bit i_seen;
    bit d_seen;
    i_seen = 1'b0;
    d_seen = 1'b0;
    @(posedge clk);
    if (do_flush) flush <= 1'b1;
    else clear <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    clear <= 1'b0;
    while (!(i_seen && d_seen)) begin
      @(posedge clk);
      if (do_flush ? iflush_done : iclear_done) i_seen = 1'b1;
      if (do_flush ? dflush_done : dclear_done) d_seen = 1'b1;
    end
    @(negedge clk);
  endtask

  task automatic report(input string name, input int err_before);
    $display("%s: %s", name, (errors == err_before) ? "ok" : "errors");
  endtask

  task automatic test_miss_hit();
    logic [WORD_W-1:0] rd;
    int e0;
    int rc;
    e0 = errors;
    cpu_access(1, 0, 32'h040, '0, '0, rd);
    check_word("dcpu_rdata miss", mem[widx(32'h040)], rd);
    rc = rd_count;
    cpu_access(1, 0, 32'h044, '0, '0, rd);  // other word of the same block
    check_word("dcpu_rdata hit", mem[widx(32'h044)], rd);
    check_count("mem reads on hit", rc, rd_count);
    cpu_access(0, 0, 32'h040, '0, '0, rd);
    check_word("icpu_rdata miss", mem[widx(32'h040)], rd);
    rc = rd_count;
    cpu_access(0, 0, 32'h040, '0, '0, rd);
    check_word("icpu_rdata hit", mem[widx(32'h040)], rd);
    check_count("mem reads on ihit", rc, rd_count);
    report("miss_hit", e0);
  endtask

  task automatic test_writeback();
    logic [WORD_W-1:0] rd;
    logic [WORD_W-1:0] merged;
    int e0;
    int wc;
    e0 = errors;
    wc = wr_count;
    merged = merge_bytes(mem[widx(32'h088)], 32'hA5C3_1E77, 4'b0101);
    cpu_access(1, 1, 32'h088, 32'hA5C3_1E77, 4'b0101, rd);
    cpu_access(1, 0, 32'h088, '0, '0, rd);
    check_word("dcpu_rdata merged", merged, rd);
    check_count("mem writes before evict", wc, wr_count);
    cpu_access(1, 0, 32'h188, '0, '0, rd);  // same index with a new tag
    check_word("dcpu_rdata evictor", mem[widx(32'h188)], rd);
    check_word("mem[0x088] after evict", merged, mem[widx(32'h088)]);
    report("writeback", e0);
  endtask

  task automatic test_bypass();
    logic [WORD_W-1:0] rd;
    int e0;
    int rc;
    int wc;
    e0 = errors;
    rc = rd_count;
    wc = wr_count;
    cpu_access(1, 0, MMIO_BASE + 32'h10, '0, '0, rd);
    check_word("dcpu_rdata mmio", mem[widx(32'h10)], rd);
    check_count("mem reads mmio", rc + 1, rd_count);
    cpu_access(1, 1, MMIO_BASE + 32'h10, 32'h1357_9BDF, 4'hF, rd);
    check_count("mem writes mmio", wc + 1, wr_count);
    check_word("mem[mmio] after write", 32'h1357_9BDF, mem[widx(32'h10)]);
    cpu_access(1, 0, MMIO_BASE + 32'h10, '0, '0, rd);  // no caching of mmio
    check_count("mem reads mmio again", rc + 2, rd_count);
    check_word("dcpu_rdata mmio again", 32'h1357_9BDF, rd);
    report("bypass", e0);
  endtask

  task automatic test_flush();
    logic [WORD_W-1:0] rd;
    int e0;
    int rc;
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      cpu_access(1, 1, 32'h200 + 32'h10 * i, 32'hF100_0000 + i, 4'hF, rd);
    end
    maintain(1);
    for (int i = 0; i < 3; i++) begin
      check_word("mem after flush", 32'hF100_0000 + i, mem[widx(32'h200 + 32'h10 * i)]);
    end
    rc = rd_count;
    cpu_access(1, 0, 32'h200, '0, '0, rd);
    check_count("mem reads after flush", rc + DEF_BLOCK_WORDS, rd_count);  // whole block refilled
    check_word("dcpu_rdata after flush", 32'hF100_0000, rd);
    report("flush", e0);
  endtask

  task automatic test_clear();
    logic [WORD_W-1:0] rd;
    logic [WORD_W-1:0] old_w;
    int e0;
    int wc;
    e0 = errors;
    old_w = mem[widx(32'h300)];
    cpu_access(1, 1, 32'h300, ~old_w, 4'hF, rd);
    wc = wr_count;
    maintain(0);
    check_count("mem writes on clear", wc, wr_count);
    cpu_access(1, 0, 32'h300, '0, '0, rd);
    check_word("dcpu_rdata after clear", old_w, rd);
    report("clear", e0);
  endtask

  task automatic test_concurrent();
    logic [WORD_W-1:0] ird;
    logic [WORD_W-1:0] drd;
    int e0;
    e0 = errors;
    fork
      cpu_access(0, 0, 32'h400, '0, '0, ird);
      cpu_access(1, 0, 32'h480, '0, '0, drd);
    join
    check_word("icpu_rdata concurrent", mem[widx(32'h400)], ird);
    check_word("dcpu_rdata concurrent", mem[widx(32'h480)], drd);
    report("concurrent", e0);
  endtask

  // watchdog
  initial begin
    #(N_TESTS * WORST_CYCLES * CLK_NS);
    $display("run did not finish in time, watchdog stopped it");
    $display("Regression failed");
    $finish;
  end

  initial begin
    errors = 0;
    checks = 0;
    rd_count = 0;
    wr_count = 0;
    rst_n = 1'b0;
    flush = 1'b0;
    clear = 1'b0;
    mem_busy = 1'b1;
    mem_rdata = '0;
    icpu_ren = 1'b0;
    icpu_wen = 1'b0;
    icpu_addr = '0;
    icpu_wdata = '0;
    icpu_be = '0;
    dcpu_ren = 1'b0;
    dcpu_wen = 1'b0;
    dcpu_addr = '0;
    dcpu_wdata = '0;
    dcpu_be = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = $random(seed);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_miss_hit();
    test_writeback();
    test_bypass();
    test_flush();
    test_clear();
    test_concurrent();
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
